// File: hw/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register file widths
`define CPU_XLEN      32
`define CPU_REG_AW    5

// first fetch address after reset
`define CPU_RESET_PC  32'h0000_0000

// highest register number, no link instruction uses it any more
`define CPU_LINK_REG  31

// instruction field positions
`define CPU_OP_FIELD      31:26
`define CPU_RS_FIELD      25:21
`define CPU_RT_FIELD      20:16
`define CPU_RD_FIELD      15:11
`define CPU_SHAMT_FIELD   10:6
`define CPU_FUNCT_FIELD   5:0
`define CPU_IMM_FIELD     15:0
`define CPU_TARGET_FIELD  25:0

`endif

// File: hw/cpu_pkg.sv
package cpu_pkg;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // funct field of R-type, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT,
        ALU_SLL, ALU_SRL,
        ALU_LUI
    } aluOp_e;

endpackage

// File: hw/instrDecoder.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module instrDecoder (
    input  logic [`CPU_XLEN-1:0]    instr_i,
    output cpu_pkg::aluOp_e         aluOp_o,
    output logic                    useImm_o,
    output logic                    regWrite_o,
    output logic                    memRead_o,
    output logic                    memWrite_o,
    output logic                    isBranch_o,
    output logic                    branchNe_o,
    output logic                    isJump_o,
    output logic [`CPU_XLEN-1:0]    imm_o,
    output logic [`CPU_REG_AW-1:0]  destReg_o
);
    logic [15:0] imm16;
    logic        zeroExt;   // andi/ori
    logic        writeRd;   // R-type writes rd, the rest rt
    logic        writes;
    logic        known;

    assign imm16 = instr_i[`CPU_IMM_FIELD];

    always_comb begin
        aluOp_o    = cpu_pkg::ALU_ADD;
        useImm_o   = 1'b0;
        memRead_o  = 1'b0;
        memWrite_o = 1'b0;
        isBranch_o = 1'b0;
        branchNe_o = 1'b0;
        isJump_o   = 1'b0;
        zeroExt    = 1'b0;
        writeRd    = 1'b0;
        writes     = 1'b0;
        known      = 1'b1;
        case (instr_i[`CPU_OP_FIELD])
            cpu_pkg::OP_RTYPE: begin
                writeRd = 1'b1;
                writes  = 1'b1;
                case (instr_i[`CPU_FUNCT_FIELD])
                    cpu_pkg::FN_ADDU: aluOp_o = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUBU: aluOp_o = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:  aluOp_o = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:   aluOp_o = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_XOR:  aluOp_o = cpu_pkg::ALU_XOR;
                    cpu_pkg::FN_SLT:  aluOp_o = cpu_pkg::ALU_SLT;
                    cpu_pkg::FN_SLL:  aluOp_o = cpu_pkg::ALU_SLL;
                    cpu_pkg::FN_SRL:  aluOp_o = cpu_pkg::ALU_SRL;
                    default:          known = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                useImm_o = 1'b1;
                writes   = 1'b1;
            end
            cpu_pkg::OP_ANDI: begin
                aluOp_o  = cpu_pkg::ALU_AND;
                useImm_o = 1'b1;
                zeroExt  = 1'b1;
                writes   = 1'b1;
            end
            cpu_pkg::OP_ORI: begin
                aluOp_o  = cpu_pkg::ALU_OR;
                useImm_o = 1'b1;
                zeroExt  = 1'b1;
                writes   = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                aluOp_o  = cpu_pkg::ALU_LUI;
                useImm_o = 1'b1;
                writes   = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                useImm_o  = 1'b1;
                memRead_o = 1'b1;
                writes    = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                useImm_o   = 1'b1;
                memWrite_o = 1'b1;
            end
            cpu_pkg::OP_BEQ: isBranch_o = 1'b1;
            cpu_pkg::OP_BNE: begin
                isBranch_o = 1'b1;
                branchNe_o = 1'b1;
            end
            cpu_pkg::OP_J:   isJump_o = 1'b1;
            default:         known = 1'b0;
        endcase
    end

    assign imm_o = zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
    assign destReg_o = writeRd ? instr_i[`CPU_RD_FIELD] : instr_i[`CPU_RT_FIELD];
    // writes to $0 are dropped here, so no later stage has to check
    assign regWrite_o = writes & known & (destReg_o != '0);

endmodule

// File: hw/regFile.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module regFile (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    we_i,
    input  logic [`CPU_REG_AW-1:0]  waddr_i,
    input  logic [`CPU_REG_AW-1:0]  raddrA_i,
    input  logic [`CPU_REG_AW-1:0]  raddrB_i,
    input  logic [`CPU_XLEN-1:0]    wdata_i,
    output logic [`CPU_XLEN-1:0]    rdataA_o,
    output logic [`CPU_XLEN-1:0]    rdataB_o
);
    logic [`CPU_XLEN-1:0] regs [0:`CPU_LINK_REG];

    // $0 reads zero, a write in flight is seen by decode in the same cycle
    function automatic logic [`CPU_XLEN-1:0] readPort(input logic [`CPU_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && addr == waddr_i) begin
            return wdata_i;   // write-before-read
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i <= `CPU_LINK_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdataA_o = readPort(raddrA_i);
    assign rdataB_o = readPort(raddrB_i);

endmodule

// File: hw/alu.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module alu (
    input  cpu_pkg::aluOp_e        op_i,
    input  logic [`CPU_XLEN-1:0]   a_i,
    input  logic [`CPU_XLEN-1:0]   b_i,
    input  logic [4:0]             shamt_i,
    output logic [`CPU_XLEN-1:0]   result_o
);
    logic lessThan;

    // slt is signed
    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            cpu_pkg::ALU_ADD: result_o = a_i + b_i;
            cpu_pkg::ALU_SUB: result_o = a_i - b_i;
            cpu_pkg::ALU_AND: result_o = a_i & b_i;
            cpu_pkg::ALU_OR:  result_o = a_i | b_i;
            cpu_pkg::ALU_XOR: result_o = a_i ^ b_i;
            cpu_pkg::ALU_SLT: begin
                result_o = {{(`CPU_XLEN-1){1'b0}}, lessThan};
            end
            // shifts act on rt, amount from the shamt field
            cpu_pkg::ALU_SLL: result_o = b_i << shamt_i;
            cpu_pkg::ALU_SRL: result_o = b_i >> shamt_i;   // logical
            cpu_pkg::ALU_LUI: result_o = b_i << 16;
            default:          result_o = '0;
        endcase
    end

endmodule

// File: hw/hazardUnit.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module hazardUnit (
    input  logic [`CPU_REG_AW-1:0]  rsD_i,
    input  logic [`CPU_REG_AW-1:0]  rtD_i,
    input  logic [`CPU_REG_AW-1:0]  rsE_i,
    input  logic [`CPU_REG_AW-1:0]  rtE_i,
    input  logic [`CPU_REG_AW-1:0]  destE_i,
    input  logic [`CPU_REG_AW-1:0]  destM_i,
    input  logic [`CPU_REG_AW-1:0]  destW_i,
    input  logic                    memReadE_i,
    input  logic                    regWriteM_i,
    input  logic                    regWriteW_i,
    input  logic                    jumpD_i,
    input  logic                    branchTakenE_i,
    input  logic                    iStall_i,
    input  logic                    dStall_i,
    output logic                    stallF_o,
    output logic                    stallD_o,
    output logic                    flushD_o,
    output logic                    flushE_o,
    output logic                    stallAll_o,
    output logic [1:0]              forwardA_o,
    output logic [1:0]              forwardB_o
);
    logic loadUse;

    // 2'b10 from memory, 2'b01 from writeback, memory is younger so it wins
    function automatic logic [1:0] fwdSel(input logic [`CPU_REG_AW-1:0] src);
        if (regWriteM_i && destM_i == src) begin
            return 2'b10;
        end else if (regWriteW_i && destW_i == src) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    assign forwardA_o = fwdSel(rsE_i);
    assign forwardB_o = fwdSel(rtE_i);

    assign stallAll_o = iStall_i | dStall_i;
    assign loadUse = memReadE_i && destE_i != '0 && (destE_i == rsD_i || destE_i == rtD_i);

    // load-use holds F and D, E gets a bubble
    assign stallF_o = stallAll_o | loadUse;
    assign stallD_o = stallAll_o | loadUse;
    assign flushE_o = ~stallAll_o & (loadUse | branchTakenE_i);
    // a held jump must not squash itself
    assign flushD_o = ~stallAll_o & (branchTakenE_i | (jumpD_i & ~loadUse));

endmodule

// File: hw/mipsPipeline.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module mipsPipeline (
    input  logic                    clk,
    input  logic                    reset_i,
    output logic [`CPU_XLEN-1:0]    instAddr_o,
    output logic                    instEn_o,
    input  logic [`CPU_XLEN-1:0]    instr_i,
    input  logic                    iStall_i,
    output logic                    memEn_o,
    output logic                    memWe_o,
    output logic [`CPU_XLEN-1:0]    memAddr_o,
    output logic [`CPU_XLEN-1:0]    memWdata_o,
    input  logic [`CPU_XLEN-1:0]    memRdata_i,
    input  logic                    dStall_i,
    output logic                    longestStall_o,
    output logic [`CPU_XLEN-1:0]    debugWbPc_o,
    output logic                    debugWbWen_o,
    output logic [`CPU_REG_AW-1:0]  debugWbWnum_o,
    output logic [`CPU_XLEN-1:0]    debugWbWdata_o
);
    logic stallF, stallD, flushD, flushE, stallAll;
    logic [1:0] forwardA, forwardB;

    // fetch
    logic [`CPU_XLEN-1:0] pcF, pcNextF, instrF;
    logic fetchActive;

    // decode
    logic [`CPU_XLEN-1:0] pcD, pcPlus4D, instrD, immD, rdataAD, rdataBD, jumpTargetD;
    logic [`CPU_REG_AW-1:0] destD, rtCheckD;
    cpu_pkg::aluOp_e aluOpD;
    cpu_pkg::opcode_e opD;
    logic useImmD, regWriteD, memReadD, memWriteD, isBranchD, branchNeD, isJumpD;
    logic rtUsedD;

    // execute
    logic [`CPU_XLEN-1:0] pcE, rsValE, rtValE, immE, srcAE, srcBE, aluBE, aluOutE;
    logic [`CPU_XLEN-1:0] branchTargetE;
    logic [`CPU_REG_AW-1:0] rsE, rtE, destE;
    logic [4:0] shamtE;
    cpu_pkg::aluOp_e aluOpE;
    logic useImmE, regWriteE, memReadE, memWriteE, isBranchE, branchNeE, branchTakenE;

    // memory and writeback
    logic [`CPU_XLEN-1:0] pcM, aluOutM, storeDataM, resultM, pcW, resultW;
    logic [`CPU_REG_AW-1:0] destM, destW;
    logic regWriteM, memReadM, memWriteM, regWriteW, wbFire;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetchActive <= 1'b0;
            pcF         <= `CPU_RESET_PC;
        end else begin
            fetchActive <= 1'b1;
            if (fetchActive && !stallF) begin   // reset PC is fetched first
                pcF <= pcNextF;
            end
        end
    end

    // taken branch in E beats a jump in D
    assign pcNextF = branchTakenE ? branchTargetE : (isJumpD ? jumpTargetD : pcF + 4);
    assign instAddr_o = pcF;
    assign instEn_o = fetchActive;
    assign instrF = fetchActive ? instr_i : '0;

    always_ff @(posedge clk) begin
        if (reset_i || flushD) begin
            instrD <= '0;   // all zeros decodes as a nop
        end else if (!stallD) begin
            instrD <= instrF;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD <= pcF;
        end
    end

    instrDecoder decoderInst (
        .instr_i(instrD), .aluOp_o(aluOpD), .useImm_o(useImmD), .regWrite_o(regWriteD),
        .memRead_o(memReadD), .memWrite_o(memWriteD), .isBranch_o(isBranchD),
        .branchNe_o(branchNeD), .isJump_o(isJumpD), .imm_o(immD), .destReg_o(destD)
    );

    regFile regFileInst (
        .clk(clk), .reset_i(reset_i), .we_i(wbFire), .waddr_i(destW),
        .raddrA_i(instrD[`CPU_RS_FIELD]), .raddrB_i(instrD[`CPU_RT_FIELD]),
        .wdata_i(resultW), .rdataA_o(rdataAD), .rdataB_o(rdataBD)
    );

    assign pcPlus4D = pcD + 4;
    assign jumpTargetD = {pcPlus4D[31:28], instrD[`CPU_TARGET_FIELD], 2'b00};

    // rt is a source only for R-type, sw and branches
    assign opD = cpu_pkg::opcode_e'(instrD[`CPU_OP_FIELD]);
    assign rtUsedD = opD == cpu_pkg::OP_RTYPE || opD == cpu_pkg::OP_SW ||
                     opD == cpu_pkg::OP_BEQ || opD == cpu_pkg::OP_BNE;
    assign rtCheckD = rtUsedD ? instrD[`CPU_RT_FIELD] : '0;

    always_ff @(posedge clk) begin
        if (reset_i || flushE) begin
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            isBranchE <= 1'b0;
        end else if (!stallAll) begin
            regWriteE <= regWriteD;
            memReadE  <= memReadD;
            memWriteE <= memWriteD;
            isBranchE <= isBranchD;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallAll) begin
            pcE       <= pcD;
            rsValE    <= rdataAD;
            rtValE    <= rdataBD;
            immE      <= immD;
            rsE       <= instrD[`CPU_RS_FIELD];
            rtE       <= instrD[`CPU_RT_FIELD];
            shamtE    <= instrD[`CPU_SHAMT_FIELD];
            destE     <= destD;
            aluOpE    <= aluOpD;
            useImmE   <= useImmD;
            branchNeE <= branchNeD;
        end
    end

    assign srcAE = forwardA[1] ? aluOutM : (forwardA[0] ? resultW : rsValE);
    assign srcBE = forwardB[1] ? aluOutM : (forwardB[0] ? resultW : rtValE);
    assign aluBE = useImmE ? immE : srcBE;

    alu aluInst (.op_i(aluOpE), .a_i(srcAE), .b_i(aluBE), .shamt_i(shamtE), .result_o(aluOutE));

    // compare on forwarded operands, not-taken is the default path
    assign branchTakenE = isBranchE & ((srcAE == srcBE) ^ branchNeE);
    assign branchTargetE = pcE + 4 + {immE[`CPU_XLEN-3:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
        end else if (!stallAll) begin
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallAll) begin
            pcM        <= pcE;
            aluOutM    <= aluOutE;
            storeDataM <= srcBE;   // forwarded rt for sw
            destM      <= destE;
        end
    end

    assign memEn_o = memReadM | memWriteM;
    assign memWe_o = memWriteM;
    assign memAddr_o = aluOutM;
    assign memWdata_o = storeDataM;
    assign resultM = memReadM ? memRdata_i : aluOutM;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteW <= 1'b0;
        end else if (!stallAll) begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallAll) begin
            pcW     <= pcM;
            resultW <= resultM;
            destW   <= destM;
        end
    end

    // W holds while stalled, so the write lands and is reported once
    assign wbFire = regWriteW & ~stallAll;
    assign debugWbWen_o = wbFire;
    assign debugWbPc_o = pcW;
    assign debugWbWnum_o = destW;
    assign debugWbWdata_o = resultW;
    assign longestStall_o = stallAll;

    hazardUnit hazardInst (
        .rsD_i(instrD[`CPU_RS_FIELD]), .rtD_i(rtCheckD), .rsE_i(rsE), .rtE_i(rtE),
        .destE_i(destE), .destM_i(destM), .destW_i(destW), .memReadE_i(memReadE),
        .regWriteM_i(regWriteM), .regWriteW_i(regWriteW), .jumpD_i(isJumpD),
        .branchTakenE_i(branchTakenE), .iStall_i(iStall_i), .dStall_i(dStall_i),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE),
        .stallAll_o(stallAll), .forwardA_o(forwardA), .forwardB_o(forwardB)
    );

endmodule

// File: test/mipsPipeline_assert.sv
`timescale 1ns/100ps

module mipsPipeline_assert (
    input logic        clk,
    input logic        reset_i,
    input logic        instEn_i,
    input logic        memEn_i,
    input logic [31:0] memAddr_i,
    input logic        iStall_i,
    input logic        dStall_i,
    input logic        debugWbWen_i,
    input logic [4:0]  debugWbWnum_i
);
    // second reset cycle on, registers are settled by then
    assert property (@(posedge clk) reset_i && $past(reset_i) |-> !instEn_i && !memEn_i)
        else $error("memory enable high during reset");

    assert property (@(posedge clk) disable iff (reset_i) (iStall_i || dStall_i) |-> !debugWbWen_i)
        else $error("debug writeback pulse while stalled");

    assert property (@(posedge clk) disable iff (reset_i) debugWbWen_i |-> debugWbWnum_i != 5'd0)
        else $error("debug writeback to register zero");

    assert property (@(posedge clk) disable iff (reset_i) memEn_i |-> memAddr_i[1:0] == 2'b00)
        else $error("data address not word aligned");

endmodule

// File: test/mipsPipeline_tb.sv
`timescale 1ns/100ps

module mipsPipeline_tb;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int PAT_DEPTH = 256;
    localparam int DMEM_WORDS = 64;
    localparam int REC_BASE = 'h40;        // count word, triples follow
    localparam int MAX_RECS = 60;
    localparam int CYCLES_PER_REC = 40;
    localparam int DRAIN_CYCLES = 20;
    localparam logic [15:0] LFSR_SEED = 16'd68;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic        clk;
    logic        reset;
    logic [31:0] instAddr, instr, memAddr, memWdata, memRdata;
    logic        instEn, iStall, memEn, memWe, dStall, longestStall;
    logic [31:0] debugWbPc, debugWbWdata;
    logic        debugWbWen;
    logic [4:0]  debugWbWnum;

    logic [31:0] patterns [0:PAT_DEPTH-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [15:0] lfsr;
    int          recCount;
    int          recIdx;

    mipsPipeline mipsPipeline_inst (
        .clk(clk), .reset_i(reset), .instAddr_o(instAddr), .instEn_o(instEn),
        .instr_i(instr), .iStall_i(iStall), .memEn_o(memEn), .memWe_o(memWe),
        .memAddr_o(memAddr), .memWdata_o(memWdata), .memRdata_i(memRdata),
        .dStall_i(dStall), .longestStall_o(longestStall), .debugWbPc_o(debugWbPc),
        .debugWbWen_o(debugWbWen), .debugWbWnum_o(debugWbWnum),
        .debugWbWdata_o(debugWbWdata)
    );

    bind mipsPipeline mipsPipeline_assert assertInst (
        .clk(clk), .reset_i(reset_i), .instEn_i(instEn_o), .memEn_i(memEn_o),
        .memAddr_i(memAddr_o), .iStall_i(iStall_i), .dStall_i(dStall_i),
        .debugWbWen_i(debugWbWen_o), .debugWbWnum_i(debugWbWnum_o)
    );

    // galois shift, one step per random bit
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? LFSR_TAPS : 16'h0000);
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            failRun($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                              $time, what, got, expected));
        end
    endtask

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // instruction memory is the program part of the pattern array
    assign instr = (instEn && instAddr[31:8] == '0) ? patterns[{2'b00, instAddr[7:2]}] : 32'h0;
    assign memRdata = dmem[memAddr[7:2]];

    always @(posedge clk) begin
        if (!reset && memEn && memWe && !dStall) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    // each stall is the AND of two bits, roughly one cycle in four
    always @(posedge clk) begin : driveStalls
        logic inReset;
        logic firstBit;
        inReset = reset;   // value at the edge
        #1;
        if (inReset) begin
            iStall = 1'b0;
            dStall = 1'b0;
        end else begin
            lfsr = lfsrStep(lfsr);
            firstBit = lfsr[0];
            lfsr = lfsrStep(lfsr);
            iStall = firstBit & lfsr[0];
            lfsr = lfsrStep(lfsr);
            firstBit = lfsr[0];
            lfsr = lfsrStep(lfsr);
            dStall = firstBit & lfsr[0];
        end
    end

    always @(posedge clk) begin : checkWriteback
        int base;
        if (!reset) begin
            checkValue("longestStall_o", {31'b0, longestStall}, {31'b0, iStall | dStall});
            if (debugWbWen) begin
                if (recIdx >= recCount) begin
                    failRun("register write seen after the last expected record");
                end else begin
                    base = REC_BASE + 1 + 3 * recIdx;
                    checkValue("debugWbPc_o", debugWbPc, patterns[base]);
                    checkValue("debugWbWnum_o", {27'b0, debugWbWnum}, patterns[base + 1]);
                    checkValue("debugWbWdata_o", debugWbWdata, patterns[base + 2]);
                    recIdx = recIdx + 1;
                end
            end
        end
    end

    initial begin : runTest
        reset = 1'b1;
        iStall = 1'b0;
        dStall = 1'b0;
        lfsr = LFSR_SEED;
        recIdx = 0;
        for (int i = 0; i < PAT_DEPTH; i++) begin
            patterns[i] = 32'h0;
        end
        $readmemh("test/program_patterns.txt", patterns);
        recCount = int'(patterns[REC_BASE]);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hDA7A_0000 + (i << 2);   // tagged with the byte address
        end
        if (recCount <= 0 || recCount > MAX_RECS) begin
            failRun("pattern file missing or its record count is out of range");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            #1 reset = 1'b0;
            wait (recIdx >= recCount);
            repeat (DRAIN_CYCLES) @(posedge clk);   // catch late extra writes
            if (recIdx == recCount) begin
                $display("RESULT: PASS");
                $finish;
            end else begin
                failRun("record count does not match the expected writebacks");
            end
        end
    end

    initial begin : watchdog
        #1;
        repeat (RESET_CYCLES + DRAIN_CYCLES + CYCLES_PER_REC * recCount) @(posedge clk);
        failRun("timeout, the expected writebacks did not all arrive");
    end

endmodule

// File: test/program_patterns.txt
// @00: program words, one per line, word address = pc / 4
// @40: record count, then one record per line: pc, register, data
@00
24010005
2402FFFD
00221821
00222023
00222824
00223025
00223826
0041402A
00014900
00025702
3C0B1234
356B5678
304CF0F0
AC0B0010
8C0D0010
01A17021
10210002
240F0001
240F0002
14210001
24100007
16010001
24110009
0800001A
24120001
24120002
241307FF
0022A02A
0800001C
@40
00000012
00000000 00000001 00000005
00000004 00000002 FFFFFFFD
00000008 00000003 00000002
0000000C 00000004 00000008
00000010 00000005 00000005
00000014 00000006 FFFFFFFD
00000018 00000007 FFFFFFF8
0000001C 00000008 00000001
00000020 00000009 00000050
00000024 0000000A 0000000F
00000028 0000000B 12340000
0000002C 0000000B 12345678
00000030 0000000C 0000F0F0
00000038 0000000D 12345678
0000003C 0000000E 1234567D
00000050 00000010 00000007
00000068 00000013 000007FF
0000006C 00000014 00000000

// File: verilog.f
+incdir+hw
hw/cpu_pkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/alu.sv
hw/hazardUnit.sv
hw/mipsPipeline.sv
test/mipsPipeline_assert.sv
test/mipsPipeline_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mipsPipeline_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := hw/cpu_defines.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
